//--- files.f
+incdir+include
source/led_panel_pkg.sv
source/store_decoder.sv
source/frame_memory.sv
source/row_scanner.sv
source/led_panel_top.sv
verif/led_panel_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run the panel testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module led_panel_tb -Mdir obj_dir -f files.f
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/Vled_panel_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -q -x "ALL TESTS PASSED"; then
	exit 0
fi
exit 1

//--- verif/led_panel_tb.sv
// directed tests of the panel driver; pixel checks only cover rows whose scan starts after the stores land
`timescale 1ns/1ps
`include "led_panel_params.svh"

module led_panel_tb;

	localparam int ROW_CYCLES = `LP_COLUMNS * 4 + `LP_LATCH_CYCLES + `LP_OE_CYCLES +
		`LP_WAIT_CYCLES;
	localparam int FRAME_CYCLES = ROW_CYCLES * `LP_ROWS;
	localparam int STORE_CYCLES = (2 ** `LP_INDEX_W) + 512; // full frame plus later stores
	localparam int WATCHDOG_CYCLES = 6 * FRAME_CYCLES + STORE_CYCLES;

	logic                    clk;
	logic                    rst;
	logic                    bus_we;
	logic [`LP_BUS_W-1:0]    bus_addr;
	logic [`LP_BUS_W-1:0]    bus_wdata;
	logic [`LP_ROW_W-1:0]    row_addr;
	logic                    display_clk;
	logic                    latch;
	logic                    display_oe;
	led_panel_pkg::pixel_t   dout_a;
	led_panel_pkg::pixel_t   dout_b;

	led_panel_pkg::pixel_t   model [2 ** `LP_INDEX_W]; // reference frame indexed by {half, row, col}
	int                      errors;
	int                      checks;

	led_panel_top dut0 (
		.clk         (clk),
		.rst         (rst),
		.bus_we      (bus_we),
		.bus_addr    (bus_addr),
		.bus_wdata   (bus_wdata),
		.row_addr    (row_addr),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe),
		.dout_a      (dout_a),
		.dout_b      (dout_b)
	);

	always #10 clk = ~clk;

	function automatic logic [`LP_BUS_W-1:0] frame_addr(input logic [15:0] region,
		input logic [`LP_INDEX_W-1:0] idx);
		frame_addr = {region, 2'b00, idx, 2'b00}; // word address in bits 13:2
	endfunction

	// one store per cycle and the model follows frame region stores only
	task automatic bus_store(input logic [`LP_BUS_W-1:0] addr, input logic [`LP_BUS_W-1:0] data);
		@(posedge clk);
		#2;
		bus_we    = 1'b1;
		bus_addr  = addr;
		bus_wdata = data;
		if (addr[`LP_BUS_W-1:16] == `LP_FB_REGION) begin
			model[addr[`LP_INDEX_W+1:2]] = data[`LP_PIXEL_W-1:0];
		end
	endtask

	task automatic bus_release();
		@(posedge clk);
		#2;
		bus_we = 1'b0;
		repeat (2) @(posedge clk); // last write lands before the next row fetch
	endtask

	task automatic check_idle_outputs();
		checks = checks + 6;
		if (display_oe !== 1'b1) begin
			$display("ERR display_oe expected %h actual %h", 1'b1, display_oe);
			errors++;
		end
		if (latch !== 1'b0) begin
			$display("ERR latch expected %h actual %h", 1'b0, latch);
			errors++;
		end
		if (display_clk !== 1'b0) begin
			$display("ERR display_clk expected %h actual %h", 1'b0, display_clk);
			errors++;
		end
		if (row_addr !== 5'h00) begin
			$display("ERR row_addr expected %h actual %h", 5'h00, row_addr);
			errors++;
		end
		if (dout_a !== 4'h0) begin
			$display("ERR dout_a expected %h actual %h", 4'h0, dout_a);
			errors++;
		end
		if (dout_b !== 4'h0) begin
			$display("ERR dout_b expected %h actual %h", 4'h0, dout_b);
			errors++;
		end
	endtask

	// returns at the first falling edge of a new row
	task automatic wait_row_change();
		logic [`LP_ROW_W-1:0] prev;
		int                   n;
		@(negedge clk);
		prev = row_addr;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (row_addr == prev && n <= ROW_CYCLES);
		if (row_addr == prev) begin
			$display("row address did not change within one row period");
			errors++;
		end
	endtask

	// walks one whole row from its first falling edge and samples mid-cycle
	task automatic scan_row(input bit check_pix);
		logic [`LP_ROW_W-1:0]   row0;
		logic [`LP_INDEX_W-1:0] idx;
		int                     pulses;
		int                     latch_cycles;
		int                     oe_cycles;
		int                     cycles;
		row0 = row_addr;
		pulses = 0;
		latch_cycles = 0;
		oe_cycles = 0;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			if (row_addr == row0) begin
				if (display_clk) begin
					if (latch_cycles > 0) begin
						$display("display_clk pulse after the row latch in row %0d", row0);
						errors++;
					end
					if (check_pix && pulses < `LP_COLUMNS) begin
						idx = {1'b0, row0, pulses[`LP_COL_W-1:0]};
						checks = checks + 2;
						if (dout_a !== model[idx]) begin
							$display("ERR dout_a row %0d col %0d expected %h actual %h",
								row0, pulses, model[idx], dout_a);
							errors++;
						end
						idx = {1'b1, row0, pulses[`LP_COL_W-1:0]};
						if (dout_b !== model[idx]) begin
							$display("ERR dout_b row %0d col %0d expected %h actual %h",
								row0, pulses, model[idx], dout_b);
							errors++;
						end
					end
					pulses++;
				end
				if (latch) begin
					if (pulses != `LP_COLUMNS || oe_cycles > 0) begin
						$display("latch high outside its phase in row %0d", row0);
						errors++;
					end
					latch_cycles++;
				end
				if (!display_oe) begin
					if (latch || latch_cycles != `LP_LATCH_CYCLES) begin
						$display("output enable active outside its phase in row %0d", row0);
						errors++;
					end
					oe_cycles++;
				end
			end
		end while (row_addr == row0 && cycles <= ROW_CYCLES);
		checks = checks + 5;
		if (pulses != `LP_COLUMNS) begin
			$display("ERR display_clk pulses expected %h actual %h", `LP_COLUMNS, pulses);
			errors++;
		end
		if (latch_cycles != `LP_LATCH_CYCLES) begin
			$display("ERR latch cycles expected %h actual %h", `LP_LATCH_CYCLES, latch_cycles);
			errors++;
		end
		if (oe_cycles != `LP_OE_CYCLES) begin
			$display("ERR display_oe low cycles expected %h actual %h", `LP_OE_CYCLES, oe_cycles);
			errors++;
		end
		if (cycles != ROW_CYCLES) begin
			$display("ERR row period expected %h actual %h", ROW_CYCLES, cycles);
			errors++;
		end
		if (row_addr !== row0 + 5'd1) begin
			$display("ERR row_addr expected %h actual %h", row0 + 5'd1, row_addr);
			errors++;
		end
	endtask

	task automatic check_reset();
		repeat (2) @(posedge clk);
		#1;
		check_idle_outputs(); // still in reset
		@(posedge clk);
		#2;
		rst = 1'b0;
		@(posedge clk); // first edge out of reset
		#1;
		check_idle_outputs();
	endtask

	task automatic check_full_frame();
		int          i;
		logic [31:0] rnd;
		for (i = 0; i < 2 ** `LP_INDEX_W; i++) begin
			rnd = $urandom;
			bus_store(frame_addr(`LP_FB_REGION, i[`LP_INDEX_W-1:0]), rnd);
		end
		bus_release();
		wait_row_change();
		for (i = 0; i < 2 * `LP_ROWS; i++) begin
			scan_row(1'b1);
		end
	endtask

	task automatic check_region_filter();
		int                     i;
		logic [31:0]            rnd;
		logic [`LP_INDEX_W-1:0] idx;
		for (i = 0; i < 16; i++) begin
			rnd = $urandom;
			idx = rnd[`LP_INDEX_W-1:0];
			bus_store(frame_addr(16'h0001, idx), {28'd0, ~model[idx]});
			bus_store(frame_addr(16'h0003, idx), {rnd[31:4], ~model[idx]});
		end
		bus_release();
		wait_row_change();
		for (i = 0; i < `LP_ROWS; i++) begin
			scan_row(1'b1);
		end
	endtask

	task automatic check_row_sequence();
		logic [`LP_ROW_W-1:0] start;
		int                   i;
		wait_row_change();
		start = row_addr;
		for (i = 0; i <= `LP_ROWS; i++) begin
			scan_row(1'b0); // one extra row covers the wrap
		end
		checks++;
		if (row_addr !== start + 5'd1) begin
			$display("ERR row_addr expected %h actual %h", start + 5'd1, row_addr);
			errors++;
		end
	endtask

	task automatic check_live_update();
		logic [`LP_ROW_W-1:0] r;
		logic [31:0]          rnd;
		int                   h;
		int                   c;
		wait_row_change();
		r = row_addr + 5'd1; // next row is rewritten while this one is shown
		for (h = 0; h < 2; h++) begin
			for (c = 0; c < `LP_COLUMNS; c++) begin
				rnd = $urandom;
				bus_store(frame_addr(`LP_FB_REGION, {h[0], r, c[`LP_COL_W-1:0]}), rnd);
			end
		end
		bus_release();
		wait_row_change();
		while (row_addr != r) begin
			scan_row(1'b0);
		end
		scan_row(1'b1);
	endtask

	initial begin
		clk       = 1'b0;
		rst       = 1'b1;
		bus_we    = 1'b0;
		bus_addr  = '0;
		bus_wdata = '0;
		errors    = 0;
		checks    = 0;
		void'($urandom(3));
		check_reset();
		check_full_frame();
		check_region_filter();
		check_row_sequence();
		check_live_update();
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// a stuck test only shows up as elapsed cycles because the scan never stops
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("checks %0d errors %0d", checks, errors);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- source/led_panel_top.sv
// hub75 style panel driver fed by host word stores; only the frame region of the bus is decoded
`timescale 1ns/1ps
`include "led_panel_params.svh"

module led_panel_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     bus_we,
	input  logic [`LP_BUS_W-1:0]     bus_addr,
	input  logic [`LP_BUS_W-1:0]     bus_wdata,
	output logic [`LP_ROW_W-1:0]     row_addr,
	output logic                     display_clk,
	output logic                     latch,
	output logic                     display_oe,
	output led_panel_pkg::pixel_t    dout_a,
	output led_panel_pkg::pixel_t    dout_b
);

	led_panel_pkg::fb_write_t    fb_wr;
	led_panel_pkg::scan_addr_t   scan_addr;
	led_panel_pkg::pixel_pair_t  scan_pix;
	logic                        scan_rd;

	store_decoder u_store_decoder (
		.clk       (clk),
		.rst       (rst),
		.bus_we    (bus_we),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.wr        (fb_wr)
	);

	frame_memory u_frame_memory (
		.clk  (clk),
		.rst  (rst),
		.wr   (fb_wr),
		.rd   (scan_rd),
		.addr (scan_addr),
		.pix  (scan_pix)
	);

	row_scanner u_row_scanner (
		.clk         (clk),
		.rst         (rst),
		.rd          (scan_rd),
		.addr        (scan_addr),
		.display_clk (display_clk),
		.latch       (latch),
		.display_oe  (display_oe)
	);

	assign row_addr = scan_addr.row; // shared by both panel halves
	assign dout_a   = scan_pix.upper;
	assign dout_b   = scan_pix.lower;

endmodule

//--- source/row_scanner.sv
// free running from reset with fixed phase lengths; a row takes 4 cycles per column plus latch, oe and blank
`timescale 1ns/1ps
`include "led_panel_params.svh"

module row_scanner (
	input  logic                        clk,
	input  logic                        rst,
	output logic                        rd,
	output led_panel_pkg::scan_addr_t   addr,
	output logic                        display_clk,
	output logic                        latch,
	output logic                        display_oe
);

	// longest of the three timed phases sizes the shared counter
	localparam int PHASE_MAX_LO = (`LP_LATCH_CYCLES > `LP_WAIT_CYCLES) ?
		`LP_LATCH_CYCLES : `LP_WAIT_CYCLES;
	localparam int PHASE_MAX = (`LP_OE_CYCLES > PHASE_MAX_LO) ?
		`LP_OE_CYCLES : PHASE_MAX_LO;
	localparam int PHASE_W = $clog2(PHASE_MAX + 1);

	localparam logic [PHASE_W-1:0] LATCH_LOAD = PHASE_W'(`LP_LATCH_CYCLES - 1);
	localparam logic [PHASE_W-1:0] OE_LOAD    = PHASE_W'(`LP_OE_CYCLES - 1);
	localparam logic [PHASE_W-1:0] WAIT_LOAD  = PHASE_W'(`LP_WAIT_CYCLES - 1);

	localparam logic [`LP_COL_W-1:0] LAST_COL = `LP_COL_W'(`LP_COLUMNS - 1);
	localparam logic [`LP_ROW_W-1:0] LAST_ROW = `LP_ROW_W'(`LP_ROWS - 1);

	typedef enum logic [2:0] {
		FETCH    = 3'd0,
		DWAIT    = 3'd1, // second memory stage in flight
		SHIFT_HI = 3'd2,
		SHIFT_LO = 3'd3,
		LATCH    = 3'd4,
		OE       = 3'd5,
		BLANK    = 3'd6
	} scan_state_t;

	scan_state_t         state;
	scan_state_t         nxt;
	logic [PHASE_W-1:0]  phase_cnt;
	logic                phase_done;
	logic                last_col;

	assign phase_done = (phase_cnt == '0);
	assign last_col   = (addr.col == LAST_COL);

	always_comb begin
		nxt = state;
		case (state)
			FETCH: begin
				nxt = DWAIT;
			end
			DWAIT: begin
				nxt = SHIFT_HI;
			end
			SHIFT_HI: begin
				nxt = SHIFT_LO;
			end
			SHIFT_LO: begin
				nxt = last_col ? LATCH : FETCH;
			end
			LATCH: begin
				if (phase_done) begin
					nxt = OE;
				end
			end
			OE: begin
				if (phase_done) begin
					nxt = BLANK;
				end
			end
			BLANK: begin
				if (phase_done) begin
					nxt = FETCH; // next row starts at column 0
				end
			end
			default: begin
				nxt = FETCH;
			end
		endcase
	end

	// panel controls are registered from the next state so they follow it without glitches
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state       <= FETCH;
			rd          <= 1'b1; // reset state is FETCH
			display_clk <= 1'b0;
			latch       <= 1'b0;
			display_oe  <= 1'b1; // drivers off
		end else begin
			state       <= nxt;
			rd          <= (nxt == FETCH);
			display_clk <= (nxt == SHIFT_HI);
			latch       <= (nxt == LATCH);
			display_oe  <= (nxt != OE); // active low
		end
	end

	// column, row and phase counters
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			addr      <= '0;
			phase_cnt <= '0;
		end else begin
			case (state)
				SHIFT_LO: begin
					if (last_col) begin
						addr.col  <= '0;
						phase_cnt <= LATCH_LOAD;
					end else begin
						addr.col <= addr.col + 1'b1;
					end
				end
				LATCH: begin
					phase_cnt <= phase_done ? OE_LOAD : phase_cnt - 1'b1;
				end
				OE: begin
					phase_cnt <= phase_done ? WAIT_LOAD : phase_cnt - 1'b1;
				end
				BLANK: begin
					if (phase_done) begin
						// row wrap
						addr.row <= (addr.row == LAST_ROW) ? '0 : addr.row + 1'b1;
					end else begin
						phase_cnt <= phase_cnt - 1'b1;
					end
				end
				default: begin
					phase_cnt <= phase_cnt;
				end
			endcase
		end
	end

endmodule

//--- source/frame_memory.sv
// one write port and two reads per rd strobe; data is valid two edges after rd is seen and a same-cycle write is not forwarded
`timescale 1ns/1ps
`include "led_panel_params.svh"

module frame_memory (
	input  logic                        clk,
	input  logic                        rst,
	input  led_panel_pkg::fb_write_t    wr,
	input  logic                        rd,
	input  led_panel_pkg::scan_addr_t   addr,
	output led_panel_pkg::pixel_pair_t  pix
);

	localparam int DEPTH = 2 ** `LP_INDEX_W;

	led_panel_pkg::pixel_t       mem [DEPTH];
	led_panel_pkg::fb_index_t    idx_upper;
	led_panel_pkg::fb_index_t    idx_lower;
	led_panel_pkg::pixel_pair_t  stage_q;

	// both halves share the row and column of the scan
	assign idx_upper = {1'b0, addr.row, addr.col};
	assign idx_lower = {1'b1, addr.row, addr.col};

	always_ff @(posedge clk) begin
		if (wr.en) begin
			mem[wr.index] <= wr.pixel;
		end
	end

	// first stage captures on rd, output stage follows one cycle later
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			stage_q <= '0;
			pix     <= '0;
		end else begin
			if (rd) begin
				stage_q.upper <= mem[idx_upper]; // old word on a write collision
				stage_q.lower <= mem[idx_lower];
			end
			pix <= stage_q; // holds until the next read reaches it
		end
	end

endmodule

//--- source/store_decoder.sv
// word stores only, byte lanes and address bits 1:0 are ignored and no store is ever stalled
`timescale 1ns/1ps
`include "led_panel_params.svh"

module store_decoder (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        bus_we,
	input  logic [`LP_BUS_W-1:0]        bus_addr,
	input  logic [`LP_BUS_W-1:0]        bus_wdata,
	output led_panel_pkg::fb_write_t    wr
);

	localparam int REGION_W = `LP_BUS_W / 2;

	logic                      hit;
	logic                      en_q;
	led_panel_pkg::fb_index_t  index_q;
	led_panel_pkg::pixel_t     pixel_q;

	// store lands in the frame memory window
	assign hit = bus_we &&
		(bus_addr[`LP_BUS_W-1 -: REGION_W] == REGION_W'(`LP_FB_REGION));

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			en_q <= 1'b0;
		end else begin
			en_q <= hit; // one write per accepted store
		end
	end

	// payload only moves on a hit
	always_ff @(posedge clk) begin
		if (hit) begin
			index_q <= bus_addr[`LP_INDEX_W+1:2]; // word address
			pixel_q <= bus_wdata[`LP_PIXEL_W-1:0];
		end
	end

	assign wr = '{en: en_q, index: index_q, pixel: pixel_q};

endmodule

//--- source/led_panel_pkg.sv
// types shared by the panel blocks; field widths come from the params header
`include "led_panel_params.svh"

package led_panel_pkg;

	// color bits of one led
	typedef logic [`LP_PIXEL_W-1:0] pixel_t;

	// word index into the frame memory
	typedef struct packed {
		logic                 half; // 0 upper panel half, 1 lower
		logic [`LP_ROW_W-1:0] row;
		logic [`LP_COL_W-1:0] col;
	} fb_index_t;

	// one pixel write
	typedef struct packed {
		logic      en;
		fb_index_t index;
		pixel_t    pixel;
	} fb_write_t;

	// pixel pair being scanned
	typedef struct packed {
		logic [`LP_ROW_W-1:0] row;
		logic [`LP_COL_W-1:0] col;
	} scan_addr_t;

	typedef struct packed {
		pixel_t upper; // drives dout_a
		pixel_t lower; // drives dout_b
	} pixel_pair_t;

endpackage

//--- include/led_panel_params.svh
// geometry, bus map and scan timing for a 64x32 pair panel; widths are not derived and must be kept in step by hand
`ifndef LED_PANEL_PARAMS_SVH
`define LED_PANEL_PARAMS_SVH

// panel geometry
`define LP_COLUMNS 64 // columns per row
`define LP_ROWS 32 // row pairs, upper and lower half share a row address

// counter widths, log2 of the geometry above
`define LP_COL_W 6
`define LP_ROW_W 5

// one pixel is the rgb bits of one led plus a spare bit
`define LP_PIXEL_W 4

// frame memory word index is {half, row, col}
`define LP_INDEX_W 12

// host bus
`define LP_BUS_W 32
`define LP_FB_REGION 16'h0002 // upper half-word of a frame store address

// scan phase lengths in clock cycles, all must be at least 1
`define LP_LATCH_CYCLES 4
`define LP_OE_CYCLES 8
`define LP_WAIT_CYCLES 6 // blanking after output enable

`endif
